/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"

obj_dir/Vfetch_front_tb: verilog.f source/*.sv tb/*.sv
	verilator --binary --assert --timing -f verilog.f --top-module fetch_front_tb -Mdir obj_dir

test: obj_dir/Vfetch_front_tb
	@out=$$(./obj_dir/Vfetch_front_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* source/branch_resolve.sv */
`timescale 1ns/1ns

module branch_resolve (
    input  fetch_pkg::branch_slot_t branch_slot,
    output fetch_pkg::redirect_t    redirect
);

    fetch_pkg::instr_u  instr;
    fetch_pkg::itype_t  itype;
    fetch_pkg::jtype_t  jtype;
    fetch_pkg::word_t   pc_plus4;
    fetch_pkg::word_t   br_offset;
    fetch_pkg::word_t   br_target;
    fetch_pkg::word_t   j_target;
    logic signed [31:0] rs_signed;
    logic               rs_zero;
    logic               rs_neg;
    logic               cond;
    logic               jump;
    logic               is_jr;

    assign instr = branch_slot.instr;
    // two views of the same word
    assign itype = instr.itype;
    assign jtype = instr.jtype;

    // delay slot address is the base for both target kinds
    assign pc_plus4 = branch_slot.pc + 32'd4;

    // sign-extended word offset
    assign br_offset = {{14{itype.imm[15]}}, itype.imm, 2'b00};
    assign br_target = pc_plus4 + br_offset;

    // region of the delay slot, index, word aligned
    assign j_target = {pc_plus4[31:28], jtype.index, 2'b00};

    // zero compares on rs
    assign rs_signed = branch_slot.rs_value;
    assign rs_zero   = branch_slot.rs_value == 32'd0;
    assign rs_neg    = rs_signed < 0;

    // jr lives under special, funct in the low immediate bits
    assign is_jr = itype.imm[5:0] == fetch_pkg::funct_jr;

    always_comb begin
        cond = 1'b0;
        jump = 1'b0;
        redirect.target = br_target;
        case (itype.opcode)
            fetch_pkg::op_beq: begin
                cond = branch_slot.rs_value == branch_slot.rt_value;
            end
            fetch_pkg::op_bne: begin
                cond = branch_slot.rs_value != branch_slot.rt_value;
            end
            fetch_pkg::op_blez: begin
                cond = rs_neg | rs_zero;
            end
            fetch_pkg::op_bgtz: begin
                cond = ~rs_neg & ~rs_zero;
            end
            fetch_pkg::op_regimm: begin
                // rt selects the compare
                if (itype.rt == fetch_pkg::regimm_bltz) begin
                    cond = rs_neg;
                end else if (itype.rt == fetch_pkg::regimm_bgez) begin
                    cond = ~rs_neg;
                end
            end
            fetch_pkg::op_j, fetch_pkg::op_jal: begin
                jump = 1'b1;
                redirect.target = j_target;
            end
            fetch_pkg::op_special: begin
                if (is_jr) begin
                    jump = 1'b1;
                    redirect.target = branch_slot.rs_value;
                end
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    // only a valid slot redirects
    assign redirect.taken = branch_slot.valid & (cond | jump);

endmodule

/* source/fetch_buffer.sv */
`timescale 1ns/1ns

module fetch_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    accept,
    input  logic                    misaligned,
    input  fetch_pkg::word_t        pc,
    input  fetch_pkg::ibus_resp_t   ibus_resp,
    input  logic                    out_ready,
    input  logic                    flush,
    output fetch_pkg::fetch_pair_t  fetch_pair,
    output logic                    hold
);

    logic             f1_valid;
    logic             f1_err;
    fetch_pkg::word_t f1_pc;
    logic             held_valid;
    fetch_pkg::pair_t held_data;
    fetch_pkg::pair_t pair_data;
    logic             load;

    // a new entry enters on a bus accept or a misaligned pc
    assign load = accept | misaligned;

    // slot full and not taken this cycle
    assign hold = f1_valid & ~out_ready;

    // fetch-1 valid and hold-buffer state
    always_ff @(posedge clk) begin
        if (reset) begin
            f1_valid   <= 1'b0;
            held_valid <= 1'b0;
        end else if (flush) begin
            // wrong-path entry dropped, incoming one too
            f1_valid   <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            if (load) begin
                f1_valid <= 1'b1;
            end else if (!hold) begin
                f1_valid <= 1'b0;
            end
            // capture once, on the first stalled cycle
            if (hold && !held_valid) begin
                held_valid <= 1'b1;
            end else if (!hold) begin
                held_valid <= 1'b0;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (load) begin
            f1_pc  <= pc;
            f1_err <= misaligned;
        end
        // later bus data may belong to repeated requests, so keep the first
        if (hold && !held_valid) begin
            held_data <= ibus_resp.data;
        end
    end

    // live response in the first cycle, hold buffer afterwards
    always_comb begin
        if (f1_err) begin
            pair_data = '0;
        end else if (held_valid) begin
            pair_data = held_data;
        end else begin
            pair_data = ibus_resp.data;
        end
    end

    assign fetch_pair.valid      = f1_valid;
    assign fetch_pair.pc         = f1_pc;
    assign fetch_pair.addr_error = f1_err;
    assign fetch_pair.instr_lo   = pair_data[31:0];
    assign fetch_pair.instr_hi   = pair_data[63:32];

endmodule

/* source/fetch_front.sv */
`timescale 1ns/1ns

module fetch_front (
    input  logic                    clk,
    input  logic                    reset,
    output fetch_pkg::ibus_req_t    ibus_req,
    input  fetch_pkg::ibus_resp_t   ibus_resp,
    input  fetch_pkg::branch_slot_t branch_slot,
    input  fetch_pkg::commit_t      commit,
    input  logic                    out_ready,
    output fetch_pkg::fetch_pair_t  fetch_pair
);

    fetch_pkg::redirect_t redirect;
    logic                 accept;
    logic                 misaligned;
    logic                 hold;

    // next pc and bus request
    pc_gen u_pc_gen (
        .clk        (clk),
        .reset      (reset),
        .ibus_resp  (ibus_resp),
        .redirect   (redirect),
        .commit     (commit),
        .hold       (hold),
        .ibus_req   (ibus_req),
        .accept     (accept),
        .misaligned (misaligned)
    );

    // slot branch outcome, also the fetch-1 flush
    branch_resolve u_branch_resolve (
        .branch_slot (branch_slot),
        .redirect    (redirect)
    );

    // fetch-1 stage and output pair
    fetch_buffer u_fetch_buffer (
        .clk        (clk),
        .reset      (reset),
        .accept     (accept),
        .misaligned (misaligned),
        .pc         (ibus_req.addr),
        .ibus_resp  (ibus_resp),
        .out_ready  (out_ready),
        .flush      (redirect.taken),
        .fetch_pair (fetch_pair),
        .hold       (hold)
    );

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    // two instructions, lower word at the lower address
    typedef logic [63:0] pair_t;

    // boot pc after reset
    localparam word_t reset_vector = 32'hbfc0_0000;
    // general exception entrance
    localparam word_t exc_entrance = 32'hbfc0_0380;
    // one instruction pair per request
    localparam word_t fetch_stride = 32'd8;

    // primary opcodes handled by the branch unit
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07
    } opcode_t;

    // rt field under regimm
    localparam logic [4:0] regimm_bltz = 5'h00;
    localparam logic [4:0] regimm_bgez = 5'h01;
    // function field under special
    localparam logic [5:0] funct_jr = 6'h08;

    // instruction bus, data follows one cycle after addr_ok
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  addr_ok;
        pair_t data;
    } ibus_resp_t;

    // i-format view
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } itype_t;

    // j-format view
    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;
    } jtype_t;

    // same word, two decodings
    typedef union packed {
        itype_t itype;
        jtype_t jtype;
    } instr_u;

    // instruction sitting in the branch slot
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
        word_t  rs_value;
        word_t  rt_value;
    } branch_slot_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // commit stage controls
    typedef struct packed {
        logic  exc;
        logic  eret;
        word_t epc;
    } commit_t;

    // pair handed downstream, instr_hi sits at pc + 4
    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  addr_error;
        word_t instr_lo;
        word_t instr_hi;
    } fetch_pair_t;

endpackage

/* source/pc_gen.sv */
`timescale 1ns/1ns

module pc_gen (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::ibus_resp_t  ibus_resp,
    input  fetch_pkg::redirect_t   redirect,
    input  fetch_pkg::commit_t     commit,
    input  logic                   hold,
    output fetch_pkg::ibus_req_t   ibus_req,
    output logic                   accept,
    output logic                   misaligned
);

    fetch_pkg::word_t pc;
    fetch_pkg::word_t pc_next;
    fetch_pkg::word_t exc_target;
    fetch_pkg::word_t exc_save;
    fetch_pkg::word_t br_save;
    logic             exc_saved;
    logic             br_saved;
    logic             exc_live;
    logic             pc_bad;
    logic             bus_accept;
    logic             stall;
    logic             advance;
    logic             enter;

    // word alignment of the pair address
    assign pc_bad = pc[1:0] != 2'b00;

    // misaligned pc never goes on the bus
    assign ibus_req.valid = ~pc_bad;
    assign ibus_req.addr  = pc;

    assign bus_accept = ibus_req.valid & ibus_resp.addr_ok;

    // waiting on addr_ok, or fetch-1 slot still occupied
    assign stall   = (~bus_accept & ~pc_bad) | hold;
    assign advance = ~stall;

    assign exc_live   = commit.exc | commit.eret;
    // exception wins over eret if both show up
    assign exc_target = commit.exc ? fetch_pkg::exc_entrance : commit.epc;

    // any pending redirect makes the current pc wrong-path
    assign enter = advance & ~(exc_saved | br_saved | exc_live | redirect.taken);
    assign accept     = bus_accept & enter;
    assign misaligned = pc_bad & enter;

    // next pc priority
    always_comb begin
        if (exc_saved) begin
            pc_next = exc_save;
        end else if (exc_live) begin
            pc_next = exc_target;
        end else if (br_saved) begin
            pc_next = br_save;
        end else if (redirect.taken) begin
            pc_next = redirect.target;
        end else begin
            pc_next = pc + fetch_pkg::fetch_stride;
        end
    end

    // pc and saved-redirect flags
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= fetch_pkg::reset_vector;
            exc_saved <= 1'b0;
            br_saved  <= 1'b0;
        end else if (advance) begin
            pc        <= pc_next;
            exc_saved <= 1'b0;
            br_saved  <= 1'b0;
        end else if (exc_live) begin
            // exception or eret replaces any saved branch
            exc_saved <= 1'b1;
            br_saved  <= 1'b0;
        end else if (redirect.taken && !exc_saved) begin
            br_saved <= 1'b1;
        end
    end

    // saved targets
    always_ff @(posedge clk) begin
        if (stall && exc_live) begin
            exc_save <= exc_target;
        end
        if (stall && redirect.taken) begin
            br_save <= redirect.target;
        end
    end

endmodule

/* tb/fetch_front_chk.sv */
`timescale 1ns/1ns

module fetch_front_chk (
    input  logic                    clk,
    input  logic                    reset,
    input  fetch_pkg::ibus_req_t    ibus_req,
    input  fetch_pkg::ibus_resp_t   ibus_resp,
    input  fetch_pkg::branch_slot_t branch_slot,
    input  logic                    out_ready,
    input  fetch_pkg::fetch_pair_t  fetch_pair
);

    // raised by any failing assertion below
    logic failed = 1'b0;

    // reset state: request at boot vector, nothing delivered
    a_reset_state: assert property (@(posedge clk)
        reset |=> ibus_req.valid && ibus_req.addr == fetch_pkg::reset_vector
            && !fetch_pair.valid)
    else begin
        $error("Error %0t ibus_req.addr expected %h got %h, valid %b, fetch_pair.valid %b",
            $time, fetch_pkg::reset_vector, ibus_req.addr, ibus_req.valid, fetch_pair.valid);
        failed = 1'b1;
    end

    // misaligned pc never reaches the bus
    a_req_aligned: assert property (@(posedge clk) disable iff (reset)
        ibus_req.valid == (ibus_req.addr[1:0] == 2'b00))
    else begin
        $error("Error %0t ibus_req.valid expected %b got %b",
            $time, ibus_req.addr[1:0] == 2'b00, ibus_req.valid);
        failed = 1'b1;
    end

    // request holds until addr_ok
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        ibus_req.valid && !ibus_resp.addr_ok |=> ibus_req == $past(ibus_req))
    else begin
        $error("Error %0t ibus_req expected %h got %h",
            $time, $past(ibus_req), ibus_req);
        failed = 1'b1;
    end

    // output pair holds under back-pressure, unless a branch flushes it
    a_pair_hold: assert property (@(posedge clk) disable iff (reset)
        fetch_pair.valid && !out_ready && !branch_slot.valid
            |=> fetch_pair == $past(fetch_pair))
    else begin
        $error("Error %0t fetch_pair expected %h got %h",
            $time, $past(fetch_pair), fetch_pair);
        failed = 1'b1;
    end

endmodule

/* tb/fetch_front_tb.sv */
`timescale 1ns/1ns

module fetch_front_tb;

    // planned stimulus is roughly 350 cycles
    localparam int cycle_limit = 1000;

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    fetch_pkg::ibus_req_t    ibus_req;
    fetch_pkg::ibus_resp_t   ibus_resp = '0;
    fetch_pkg::branch_slot_t branch_slot = '0;
    fetch_pkg::commit_t      commit = '0;
    logic                    out_ready = 1'b0;
    fetch_pkg::fetch_pair_t  fetch_pair;

    integer           seed = 62;
    logic             bus_stall = 1'b0;
    int               cycles = 0;
    // handshake draw for the coming falling edge
    logic [31:0]      hs_rand = '0;
    // bus model state
    logic             acc_valid = 1'b0;
    fetch_pkg::word_t acc_addr = '0;
    // expected next request address
    fetch_pkg::word_t prev_addr = '0;
    fetch_pkg::word_t pend = '0;
    logic             pend_v = 1'b0;
    logic             pend_exc = 1'b0;
    logic [32:0]      slot_result;

    fetch_front u_dut (
        .clk         (clk),
        .reset       (reset),
        .ibus_req    (ibus_req),
        .ibus_resp   (ibus_resp),
        .branch_slot (branch_slot),
        .commit      (commit),
        .out_ready   (out_ready),
        .fetch_pair  (fetch_pair)
    );

    bind fetch_front fetch_front_chk u_chk (
        .clk         (clk),
        .reset       (reset),
        .ibus_req    (ibus_req),
        .ibus_resp   (ibus_resp),
        .branch_slot (branch_slot),
        .out_ready   (out_ready),
        .fetch_pair  (fetch_pair)
    );

    always #50 clk = ~clk;

    // {taken, target} worked out from the branch rules
    function automatic logic [32:0] resolve_slot(input fetch_pkg::branch_slot_t s);
        logic [31:0] w;
        logic [31:0] pc4;
        logic [31:0] btarget;
        logic        taken;
        logic [31:0] target;
        w = s.instr;
        pc4 = s.pc + 32'd4;
        btarget = pc4 + ({{16{w[15]}}, w[15:0]} << 2);
        taken = 1'b0;
        target = btarget;
        case (w[31:26])
            6'h04: taken = s.rs_value == s.rt_value;
            6'h05: taken = s.rs_value != s.rt_value;
            6'h06: taken = $signed(s.rs_value) <= 0;
            6'h07: taken = $signed(s.rs_value) > 0;
            6'h01: begin
                if (w[20:16] == 5'd0) taken = $signed(s.rs_value) < 0;
                if (w[20:16] == 5'd1) taken = $signed(s.rs_value) >= 0;
            end
            6'h02, 6'h03: begin
                taken = 1'b1;
                target = {pc4[31:28], w[25:0], 2'b00};
            end
            6'h00: begin
                taken = w[5:0] == 6'h08;
                target = s.rs_value;
            end
            default: taken = 1'b0;
        endcase
        return {taken & s.valid, target};
    endfunction

    task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        $display("Error %0t %s expected %h got %h", $time, name, exp, got);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // draws made on the rising edge
    always @(posedge clk) begin
        hs_rand <= $random(seed);
    end

    // random handshakes, memory returns {addr + 4, addr} one cycle after accept
    always @(negedge clk) begin
        ibus_resp.addr_ok = hs_rand[0] & ~bus_stall;
        out_ready = hs_rand[1] | hs_rand[2];
        if (acc_valid) begin
            ibus_resp.data = {acc_addr + 32'd4, acc_addr};
        end else begin
            // nothing returned, data lines carry junk
            ibus_resp.data = {~hs_rand, hs_rand};
        end
    end

    always @(posedge clk) begin
        acc_valid <= ibus_req.valid & ibus_resp.addr_ok;
        acc_addr  <= ibus_req.addr;
        cycles    <= cycles + 1;
    end

    // redirect bookkeeping, exception beats a branch
    assign slot_result = resolve_slot(branch_slot);
    always @(posedge clk) begin
        prev_addr <= ibus_req.addr;
        if (reset) begin
            pend_v   <= 1'b0;
            pend_exc <= 1'b0;
        end else begin
            if (ibus_req.addr != prev_addr) begin
                pend_v   <= 1'b0;
                pend_exc <= 1'b0;
            end
            if (commit.exc || commit.eret) begin
                pend     <= commit.exc ? fetch_pkg::exc_entrance : commit.epc;
                pend_v   <= 1'b1;
                pend_exc <= 1'b1;
            end else if (slot_result[32] && (!pend_exc || ibus_req.addr != prev_addr)) begin
                pend   <= slot_result[31:0];
                pend_v <= 1'b1;
            end
        end
    end

    // each new request: redirect target or sequential plus 8
    always @(posedge clk) begin
        if (!reset && ibus_req.addr != prev_addr) begin
            assert (ibus_req.addr == (pend_v ? pend : prev_addr + fetch_pkg::fetch_stride))
            else fail_value("ibus_req.addr", 64'(pend_v ? pend : prev_addr + 32'd8),
                64'(ibus_req.addr));
        end
    end

    // misaligned pc comes out as address error
    always @(posedge clk) begin
        if (!reset && fetch_pair.valid) begin
            assert (fetch_pair.addr_error == (fetch_pair.pc[1:0] != 2'b00))
            else fail_value("fetch_pair.addr_error", 64'(fetch_pair.pc[1:0] != 2'b00),
                64'(fetch_pair.addr_error));
        end
    end

    // pair contents mirror the memory model
    always @(posedge clk) begin
        if (!reset && fetch_pair.valid && !fetch_pair.addr_error) begin
            assert ({fetch_pair.instr_hi, fetch_pair.instr_lo}
                == {fetch_pair.pc + 32'd4, fetch_pair.pc})
            else fail_value("fetch_pair.instr", {fetch_pair.pc + 32'd4, fetch_pair.pc},
                {fetch_pair.instr_hi, fetch_pair.instr_lo});
        end
    end

    // bound checker raised its flag
    always @(negedge clk) begin
        if (u_dut.u_chk.failed) begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (cycles >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // let the redirect reach the bus, then a few quiet cycles
    task automatic settle();
        while (pend_v) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    task automatic drive_slot(input logic [31:0] word, input logic [31:0] rs,
                              input logic [31:0] rt);
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        branch_slot = {1'b1, {r[31:2], 2'b00}, word, rs, rt};
        @(negedge clk);
        branch_slot.valid = 1'b0;
    endtask

    task automatic drive_commit(input logic exc, input logic eret, input logic [31:0] epc);
        @(negedge clk);
        commit = {exc, eret, epc};
        @(negedge clk);
        commit = '0;
    endtask

    // one slot of the given kind with random operands
    task automatic branch_kind(input int kind);
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] imm;
        rs = $random(seed);
        rt = $random(seed);
        imm = $random(seed);
        // zero and equal operands often enough
        if (imm[20]) rs = '0;
        if (imm[21]) rt = rs;
        case (kind)
            0: drive_slot({6'h04, 5'd1, 5'd2, imm[15:0]}, rs, rt);
            1: drive_slot({6'h05, 5'd1, 5'd2, imm[15:0]}, rs, rt);
            2: drive_slot({6'h06, 5'd1, 5'd0, imm[15:0]}, rs, rt);
            3: drive_slot({6'h07, 5'd1, 5'd0, imm[15:0]}, rs, rt);
            4: drive_slot({6'h01, 5'd1, 5'd0, imm[15:0]}, rs, rt);
            5: drive_slot({6'h01, 5'd1, 5'd1, imm[15:0]}, rs, rt);
            6: drive_slot({6'h02, rt[25:0]}, rs, rt);
            7: drive_slot({6'h03, rt[25:0]}, rs, rt);
            default: drive_slot({6'h00, 5'd1, 15'd0, 6'h08}, {rt[31:2], 2'b00}, rt);
        endcase
        settle();
    endtask

    initial begin
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // sequential flow with random handshakes
        repeat (40) @(negedge clk);
        for (int i = 0; i < 18; i++) begin
            branch_kind(i % 9);
        end
        drive_commit(1'b1, 1'b0, '0);
        settle();
        drive_commit(1'b0, 1'b1, 32'h8000_1000);
        settle();
        // misaligned return address, then recover through an exception
        drive_commit(1'b0, 1'b1, 32'h8000_2002);
        settle();
        repeat (20) @(negedge clk);
        drive_commit(1'b1, 1'b0, '0);
        settle();
        // jump while addr_ok is held low
        @(posedge clk);
        bus_stall = 1'b1;
        drive_slot({6'h02, 26'h0123456}, 32'd0, 32'd0);
        repeat (3) @(negedge clk);
        @(posedge clk);
        bus_stall = 1'b0;
        settle();
        // exception then branch in one stall
        @(posedge clk);
        bus_stall = 1'b1;
        drive_commit(1'b1, 1'b0, '0);
        drive_slot({6'h04, 5'd1, 5'd2, 16'h0040}, 32'd5, 32'd5);
        repeat (2) @(negedge clk);
        @(posedge clk);
        bus_stall = 1'b0;
        settle();
        // branch then return in one stall
        @(posedge clk);
        bus_stall = 1'b1;
        drive_slot({6'h04, 5'd1, 5'd2, 16'h0080}, 32'd7, 32'd7);
        drive_commit(1'b0, 1'b1, 32'h8000_3000);
        repeat (2) @(negedge clk);
        @(posedge clk);
        bus_stall = 1'b0;
        settle();
        repeat (10) @(negedge clk);
        if (u_dut.u_chk.failed) begin
            $display("Some tests failed");
            $fatal(1);
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* verilog.f */
source/fetch_pkg.sv
source/pc_gen.sv
source/branch_resolve.sv
source/fetch_buffer.sv
source/fetch_front.sv
tb/fetch_front_chk.sv
tb/fetch_front_tb.sv
